//--- dv/synth_patterns.txt
# Hex fields: REG adrs wd expected | MEM adrs data | MIDI byte stop
# RUN start end add loop
REG 4 0003ff12 0003ff12
REG 8 12345678 12345678
REG c 00000007 00000007
REG 14 deadbeef 00000000
REG 40 00000001 00000000
MIDI 90 1
MIDI 3c 1
MIDI 55 0
MIDI 7f 1
MEM a 1111
MEM c 2a2b
MEM e 3c3d
MEM 10 4e4f
MEM 14 8001
MEM 15 9002
MEM 16 a003
MEM 1e 0bad
MEM 21 0cab
MEM 24 0dd1
RUN a 10 2 0
RUN 1e 23 3 0
RUN 14 16 1 1

//--- compile.f
+incdir+hw
hw/SynthBusPkg.sv
hw/SynthAudioPkg.sv
hw/SynthesizerCsr.sv
hw/UfiReadDma.sv
hw/UartRx.sv
hw/I2SSignalGen.sv
hw/SynthesizerBlock.sv
dv/SynthesizerBlockTb.sv

//--- Bender.yml
package:
  name: synthesizer_block

sources:
  - include_dirs:
      - hw
    files:
      - hw/SynthBusPkg.sv
      - hw/SynthAudioPkg.sv
      - hw/SynthesizerCsr.sv
      - hw/UfiReadDma.sv
      - hw/UartRx.sv
      - hw/I2SSignalGen.sv
      - hw/SynthesizerBlock.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/SynthesizerBlockTb.sv

//--- dv/SynthesizerBlockTb.sv
// Synthesizer peripheral testbench

`timescale 1ns/10ps
`include "synth_defines.svh"

module SynthesizerBlockTb;
	import SynthBusPkg::*;
	import SynthAudioPkg::*;

	logic                        clk;
	logic                        rst;
	usiWrT                       usiWr;
	logic [`SYNTH_USI_WIDTH-1:0] usiRdAdrs;
	ufiRspT                      ufiRsp;
	logic                        midiRx;
	logic [`SYNTH_USI_WIDTH-1:0] usiRd;
	ufiReqT                      ufiReq;
	logic [7:0]                  midiRd;
	logic                        midiVd;
	logic                        i2sMclk;
	logic                        i2sBclk;
	logic                        i2sLrclk;
	logic                        i2sSdata;

	// Sample memory, frames and MIDI bytes seen
	logic [15:0] memData [int];
	logic [63:0] frameQ [$];
	logic [7:0]  midiQ [$];
	string       lineQ [$];
	int          mismatchCount = 0;
	int          failCount = 0;
	int          cycleCount = 0;
	int          cycleLimit = 0;

	SynthesizerBlock dut_i (
		.clk       (clk),
		.rst       (rst),
		.usiWr     (usiWr),
		.usiRdAdrs (usiRdAdrs),
		.ufiRsp    (ufiRsp),
		.midiRx    (midiRx),
		.usiRd     (usiRd),
		.ufiReq    (ufiReq),
		.midiRd    (midiRd),
		.midiVd    (midiVd),
		.i2sMclk   (i2sMclk),
		.i2sBclk   (i2sBclk),
		.i2sLrclk  (i2sLrclk),
		.i2sSdata  (i2sSdata)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// ---------------------------------------------------------------------
	// Watchdog
	// ---------------------------------------------------------------------
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycleCount);
			$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount + 1);
			$display("Simulation failed");
			$finish;
		end
	end

	// Unloaded words get a pattern from the full address
	function automatic logic [15:0] memRead(input logic [17:0] adrs);
		if (memData.exists(int'(adrs)))
			return memData[int'(adrs)];
		return adrs[15:0] ^ {adrs[17:16], adrs[17:4]} ^ 16'h5A5A;
	endfunction

	// Memory model with a random latency of 1 to 6 cycles
	always
	begin
		int lat;
		@(negedge clk);
		ufiRsp.rdy = 1'b0;
		if (ufiReq.req)
		begin
			lat = $urandom_range(1, 6);
			repeat (lat - 1) @(negedge clk);
			ufiRsp.rd  = memRead(ufiReq.adrs);
			ufiRsp.rdy = 1'b1;
		end
	end

	// MIDI strobes sampled away from the clock edge
	always @(negedge clk)
	begin
		if (midiVd)
			midiQ.push_back(midiRd);
	end

	// ---------------------------------------------------------------------
	// I2S monitor
	// ---------------------------------------------------------------------
	// First bit after an lrclk edge is the LSB of the previous half
	logic [30:0] i2sAcc;
	logic [31:0] leftWord;
	logic        prevLr = 1'b0;
	always @(posedge i2sBclk)
	begin
		if (i2sLrclk != prevLr)
		begin
			if (!prevLr)
				leftWord = {i2sAcc, i2sSdata};
			else
				frameQ.push_back({leftWord, i2sAcc, i2sSdata});
		end
		else
			i2sAcc = {i2sAcc[29:0], i2sSdata};
		prevLr = i2sLrclk;
	end

	task automatic writeReg(input logic [31:0] adrs, input logic [31:0] wd);
		@(negedge clk);
		usiWr = '{wrEn: 1'b1, adrs: adrs, wd: wd};
		@(negedge clk);
		usiWr.wrEn = 1'b0;
	endtask

	// Registered read with data valid one cycle after the address
	task automatic readReg(input logic [31:0] adrs, output logic [31:0] rd);
		@(negedge clk);
		usiRdAdrs = adrs;
		@(negedge clk);
		rd = usiRd;
	endtask

	task automatic checkReg(input logic [31:0] adrs, input logic [31:0] expVal);
		logic [31:0] rd;
		readReg(adrs, rd);
		if (rd !== expVal)
		begin
			$display("Mismatch at %0t: usiRd[%0h] expected %h got %h", $time, adrs, expVal, rd);
			mismatchCount++;
		end
	endtask

	task automatic nextFrame(output logic [31:0] l, output logic [31:0] r);
		while (frameQ.size() == 0)
			@(negedge clk);
		{l, r} = frameQ.pop_front();
	endtask

	// Both halves equal with pad and low bits zero
	task automatic frameSample(output logic [15:0] sample);
		logic [31:0] l;
		logic [31:0] r;
		nextFrame(l, r);
		if (l !== r)
		begin
			$display("Mismatch at %0t: i2s right word expected %h got %h", $time, l, r);
			mismatchCount++;
		end
		if (l[31] !== 1'b0 || l[14:0] !== 15'd0)
		begin
			$display("Mismatch at %0t: i2s word pad bits expected 0 got %h", $time, l);
			mismatchCount++;
		end
		sample = l[30:15];
	endtask

	// Let the transmitter settle, then drop what it sent
	task automatic skipFrames(input int count);
		logic [31:0] l;
		logic [31:0] r;
		frameQ.delete();
		repeat (count) nextFrame(l, r);
	endtask

	task automatic sendMidi(input logic [7:0] data, input logic stopBit);
		logic [9:0] bits;
		bits = {stopBit, data, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			@(negedge clk);
			midiRx = bits[i];
			repeat (`SYNTH_MIDI_BAUD_DIV - 1) @(negedge clk);
		end
		@(negedge clk);
		midiRx = 1'b1;
		repeat (2 * `SYNTH_MIDI_BAUD_DIV) @(negedge clk);
		if (stopBit && midiQ.size() != 1)
		begin
			$display("MIDI byte %h gave %0d strobes instead of one", data, midiQ.size());
			failCount++;
		end
		else if (stopBit && midiQ[0] !== data)
		begin
			$display("Mismatch at %0t: midiRd expected %h got %h", $time, data, midiQ[0]);
			mismatchCount++;
		end
		else if (!stopBit && midiQ.size() != 0)
		begin
			$display("MIDI byte %h with a low stop bit was strobed out", data);
			failCount++;
		end
		midiQ.delete();
	endtask

	// ---------------------------------------------------------------------
	// Playback run
	// ---------------------------------------------------------------------
	task automatic runPlayback(input logic [17:0] startA, input logic [17:0] endA,
		input logic [17:0] addA, input logic loop);
		logic [15:0] expQ [$];
		logic [17:0] adrs;
		logic [15:0] sample;
		int          needed;
		int          idx;
		// Fetched address at or past the end closes the pass
		adrs = startA;
		expQ.push_back(memRead(adrs));
		while (adrs < endA)
		begin
			adrs = adrs + addA;
			expQ.push_back(memRead(adrs));
		end
		needed = loop ? 2 * expQ.size() + 1 : expQ.size();
		writeReg(`SYNTH_REG_START, startA);
		writeReg(`SYNTH_REG_END, endA);
		writeReg(`SYNTH_REG_ADD, addA);
		skipFrames(2);
		frameQ.delete();
		writeReg(`SYNTH_REG_CTRL, {30'd0, loop, 1'b1});
		idx = 0;
		while (idx < needed)
		begin
			frameSample(sample);
			if (sample === 16'd0 && idx > 0)
			begin
				$display("Silent frame in the middle of playback after %0d samples", idx);
				failCount++;
			end
			else if (sample !== 16'd0)
			begin
				if (sample !== expQ[idx % expQ.size()])
				begin
					$display("Mismatch at %0t: i2s sample %0d expected %h got %h", $time, idx,
						expQ[idx % expQ.size()], sample);
					mismatchCount++;
				end
				idx++;
			end
		end
		if (!loop)
		begin
			// Only silence after the last sample
			repeat (3)
			begin
				frameSample(sample);
				if (sample !== 16'd0)
				begin
					$display("Mismatch at %0t: i2s trailing sample expected 0000 got %h", $time,
						sample);
					mismatchCount++;
				end
			end
			checkReg(`SYNTH_REG_STATUS, 32'd1);
		end
		// Stop the DMA first so no new pass sets done again
		writeReg(`SYNTH_REG_CTRL, 32'd0);
		writeReg(`SYNTH_REG_STATUS, 32'd1);
		checkReg(`SYNTH_REG_STATUS, 32'd0);
	endtask

	// Outputs held low while the transmitter reset bit is set
	task automatic checkI2sReset();
		logic prevMclk;
		logic prevBclk;
		int   bclkEdges;
		writeReg(`SYNTH_REG_CTRL, 32'd1 << `SYNTH_CTRL_I2S_RST);
		repeat (300)
		begin
			@(negedge clk);
			if ({i2sMclk, i2sBclk, i2sLrclk, i2sSdata} !== 4'b0000)
			begin
				$display("Mismatch at %0t: i2s outputs expected 0 got %b", $time,
					{i2sMclk, i2sBclk, i2sLrclk, i2sSdata});
				mismatchCount++;
			end
		end
		writeReg(`SYNTH_REG_CTRL, 32'd0);
		// mclk flips every cycle, bclk every second cycle
		prevMclk  = i2sMclk;
		prevBclk  = i2sBclk;
		bclkEdges = 0;
		repeat (16)
		begin
			@(negedge clk);
			if (i2sMclk === prevMclk)
			begin
				$display("Mismatch at %0t: i2sMclk expected %b got %b", $time,
					~prevMclk, i2sMclk);
				mismatchCount++;
			end
			if (i2sBclk !== prevBclk)
				bclkEdges++;
			prevMclk = i2sMclk;
			prevBclk = i2sBclk;
		end
		if (bclkEdges != 8)
		begin
			$display("Mismatch at %0t: i2sBclk edges in 16 cycles expected 8 got %0d", $time,
				bclkEdges);
			mismatchCount++;
		end
		skipFrames(2);
	endtask

	// ---------------------------------------------------------------------
	// Main sequence
	// ---------------------------------------------------------------------
	initial
	begin
		int          fd;
		int          cnt;
		int          samples;
		string       line;
		string       tag;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [17:0] a;
		clk = 1'b0;
		rst = 1'b1;
		usiWr = '0;
		usiRdAdrs = '0;
		ufiRsp = '0;
		midiRx = 1'b1;
		void'($urandom(93657));
		samples = 0;
		fd = $fopen("dv/synth_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the pattern file");
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			// First pass loads memory and sizes the watchdog
			while (!$feof(fd))
			begin
				line = "";
				cnt = $fgets(line, fd);
				cnt = $sscanf(line, "%s %h %h %h %h", tag, f0, f1, f2, f3);
				if (cnt < 1 || tag.substr(0, 0) == "#")
					continue;
				lineQ.push_back(line);
				if (tag == "MEM")
					memData[int'(f0)] = f1[15:0];
				else if (tag == "RUN")
				begin
					a = f0[17:0];
					cnt = 1;
					while (a < f1[17:0])
					begin
						a = a + f2[17:0];
						cnt++;
					end
					samples += f3[0] ? 2 * cnt + 1 : cnt;
				end
			end
			$fclose(fd);
			cycleLimit = 200 * lineQ.size() + 4000 * samples;
			repeat (10) @(negedge clk);
			rst = 1'b0;
			foreach (lineQ[i])
			begin
				cnt = $sscanf(lineQ[i], "%s %h %h %h %h", tag, f0, f1, f2, f3);
				if (tag == "REG")
				begin
					writeReg(f0, f1);
					checkReg(f0, f2);
				end
				else if (tag == "MIDI")
					sendMidi(f0[7:0], f1[0]);
				else if (tag == "RUN")
					runPlayback(f0[17:0], f1[17:0], f2[17:0], f3[0]);
			end
			checkI2sReset();
			$display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
			if (mismatchCount == 0 && failCount == 0)
				$display("Simulation completed successfully");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

//--- hw/SynthesizerBlock.sv
// Synthesizer peripheral top level

`timescale 1ns/10ps
`include "synth_defines.svh"

module SynthesizerBlock (
	input  logic                          clk,
	input  logic                          rst,
	input  SynthBusPkg::usiWrT            usiWr,
	input  logic [`SYNTH_USI_WIDTH-1:0]   usiRdAdrs,
	input  SynthBusPkg::ufiRspT           ufiRsp,
	input  logic                          midiRx,
	output logic [`SYNTH_USI_WIDTH-1:0]   usiRd,
	output SynthBusPkg::ufiReqT           ufiReq,
	output logic [7:0]                    midiRd,
	output logic                          midiVd,
	output logic                          i2sMclk,
	output logic                          i2sBclk,
	output logic                          i2sLrclk,
	output logic                          i2sSdata
);
	import SynthAudioPkg::*;

	dmaCfgT                         dmaCfg;
	logic                           dmaDone;
	logic                           i2sRst;
	logic                           i2sBlockRst;
	logic [`SYNTH_UFI_DQ_WIDTH-1:0] dmaRd;
	logic                           dmaRvd;
	logic                           dmaRe;
	audioWordT                      audioData;

	// ---------------------------------------------------------------------
	// Registers
	// ---------------------------------------------------------------------
	SynthesizerCsr csr_i (
		.clk       (clk),
		.rst       (rst),
		.usiWr     (usiWr),
		.usiRdAdrs (usiRdAdrs),
		.dmaDone   (dmaDone),
		.usiRd     (usiRd),
		.dmaCfg    (dmaCfg),
		.i2sRst    (i2sRst)
	);

	// Sample fetch
	UfiReadDma dma_i (
		.clk    (clk),
		.rst    (rst),
		.dmaCfg (dmaCfg),
		.ufiRsp (ufiRsp),
		.dmaRe  (dmaRe),
		.ufiReq (ufiReq),
		.dmaDone(dmaDone),
		.dmaRd  (dmaRd),
		.dmaRvd (dmaRvd)
	);

	// MIDI input
	UartRx midi_i (
		.clk    (clk),
		.rst    (rst),
		.midiRx (midiRx),
		.midiRd (midiRd),
		.midiVd (midiVd)
	);

	// ---------------------------------------------------------------------
	// Audio output
	// ---------------------------------------------------------------------
	// Underrun sends a silent frame
	always_comb
	begin
		audioData.pad    = 1'b0;
		audioData.sample = dmaRvd ? dmaRd : '0;
		audioData.zero   = '0;
	end

	// Host can hold the transmitter in reset
	assign i2sBlockRst = rst | i2sRst;

	I2SSignalGen i2s_i (
		.clk          (clk),
		.rst          (i2sBlockRst),
		.audioData    (audioData),
		.audioDataRdy (dmaRe),
		.i2sMclk      (i2sMclk),
		.i2sBclk      (i2sBclk),
		.i2sLrclk     (i2sLrclk),
		.i2sSdata     (i2sSdata)
	);

endmodule

//--- hw/I2SSignalGen.sv
// I2S transmitter

`timescale 1ns/10ps
`include "synth_defines.svh"

module I2SSignalGen (
	input  logic                     clk,
	input  logic                     rst,
	input  SynthAudioPkg::audioWordT audioData,
	output logic                     audioDataRdy,
	output logic                     i2sMclk,
	output logic                     i2sBclk,
	output logic                     i2sLrclk,
	output logic                     i2sSdata
);
	import SynthAudioPkg::*;

	localparam int bclkDiv  = `SYNTH_I2S_BCLK_DIV;
	localparam int divWidth = (bclkDiv > 1) ? $clog2(bclkDiv) : 1;

	logic [divWidth-1:0] divCnt;
	logic                bclkTick;
	logic                bclkFall;
	logic [5:0]          slotCnt;
	logic [5:0]          nextSlot;
	logic [4:0]          bitSel;
	audioWordT           curWord;

	assign bclkTick = (divCnt == divWidth'(bclkDiv - 1));
	// bclk high now, so this tick is a falling edge
	assign bclkFall = bclkTick & i2sBclk;
	assign nextSlot = slotCnt + 6'd1;
	// Slot k carries bit 32-k, slot 0 still carries bit 0 of the previous word
	assign bitSel   = 5'd0 - nextSlot[4:0];

	// Frame start, same cycle the word is taken
	assign audioDataRdy = bclkFall & (nextSlot == 6'd0);

	// ---------------------------------------------------------------------
	// Clock dividers and serializer
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			i2sMclk  <= 1'b0;
			i2sBclk  <= 1'b0;
			i2sLrclk <= 1'b0;
			i2sSdata <= 1'b0;
			divCnt   <= '0;
			// First falling edge lands on slot 0
			slotCnt  <= 6'd63;
		end
		else
		begin
			i2sMclk <= ~i2sMclk;
			divCnt  <= bclkTick ? '0 : divCnt + 1'b1;
			if (bclkTick)
				i2sBclk <= ~i2sBclk;
			// Everything moves on the falling bclk edge
			if (bclkFall)
			begin
				slotCnt  <= nextSlot;
				// Left half low, right half high
				i2sLrclk <= nextSlot[5];
				i2sSdata <= curWord[bitSel];
			end
		end
	end

	// Word held for both halves of the frame
	always_ff @(posedge clk)
	begin
		if (rst)
			curWord <= '0;
		else if (audioDataRdy)
			curWord <= audioData;
	end

endmodule

//--- hw/UartRx.sv
// MIDI serial receiver

`timescale 1ns/10ps
`include "synth_defines.svh"

module UartRx (
	input  logic       clk,
	input  logic       rst,
	input  logic       midiRx,
	output logic [7:0] midiRd,
	output logic       midiVd
);
	import SynthAudioPkg::*;

	localparam int baudDiv  = `SYNTH_MIDI_BAUD_DIV;
	localparam int cntWidth = $clog2(baudDiv);

	uartStateT           state;
	logic [1:0]          rxSync;
	logic                rxPrev;
	logic                rxFall;
	logic [cntWidth-1:0] baudCnt;
	logic                halfTick;
	logic                fullTick;
	logic [2:0]          bitCnt;
	logic [7:0]          shiftReg;

	// Two-flop synchronizer plus edge history, idle high
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rxSync <= 2'b11;
			rxPrev <= 1'b1;
		end
		else
		begin
			rxSync <= {rxSync[0], midiRx};
			rxPrev <= rxSync[1];
		end
	end

	assign rxFall   = rxPrev & ~rxSync[1];
	// Middle of the start bit
	assign halfTick = (baudCnt == cntWidth'(baudDiv / 2 - 1));
	// One full bit later
	assign fullTick = (baudCnt == cntWidth'(baudDiv - 1));

	// ---------------------------------------------------------------------
	// Bit sampler
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= UART_IDLE;
			baudCnt <= '0;
			bitCnt  <= '0;
			midiRd  <= '0;
			midiVd  <= 1'b0;
		end
		else
		begin
			midiVd <= 1'b0;
			case (state)
				UART_IDLE:
				begin
					baudCnt <= '0;
					if (rxFall)
						state <= UART_START;
				end
				UART_START:
				begin
					if (halfTick)
					begin
						baudCnt <= '0;
						bitCnt  <= '0;
						// Glitch check, line must still be low
						state   <= rxSync[1] ? UART_IDLE : UART_DATA;
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				UART_DATA:
				begin
					if (fullTick)
					begin
						baudCnt  <= '0;
						// LSB first
						shiftReg <= {rxSync[1], shiftReg[7:1]};
						bitCnt   <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= UART_STOP;
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				UART_STOP:
				begin
					if (fullTick)
					begin
						// Framing error drops the byte
						if (rxSync[1])
						begin
							midiRd <= shiftReg;
							midiVd <= 1'b1;
						end
						state <= UART_IDLE;
					end
					else
						baudCnt <= baudCnt + 1'b1;
				end
				default: state <= UART_IDLE;
			endcase
		end
	end

endmodule

//--- hw/UfiReadDma.sv
// Sample memory read DMA

`timescale 1ns/10ps
`include "synth_defines.svh"

module UfiReadDma (
	input  logic                            clk,
	input  logic                            rst,
	input  SynthAudioPkg::dmaCfgT           dmaCfg,
	input  SynthBusPkg::ufiRspT             ufiRsp,
	input  logic                            dmaRe,
	output SynthBusPkg::ufiReqT             ufiReq,
	output logic                            dmaDone,
	output logic [`SYNTH_UFI_DQ_WIDTH-1:0]  dmaRd,
	output logic                            dmaRvd
);
	import SynthAudioPkg::*;

	localparam int fifoDepth = `SYNTH_DMA_FIFO_DEPTH;
	localparam int ptrWidth  = (fifoDepth > 1) ? $clog2(fifoDepth) : 1;
	localparam int cntWidth  = $clog2(fifoDepth + 1);

	dmaStateT                         state;
	logic                             enPrev;
	logic                             enRise;
	logic [`SYNTH_DMA_ADRS_WIDTH-1:0] curAdrs;
	logic                             lastAdrs;
	logic                             push;
	logic                             pop;
	logic [`SYNTH_UFI_DQ_WIDTH-1:0]   fifoMem [fifoDepth];
	logic [ptrWidth-1:0]              wrPtr;
	logic [ptrWidth-1:0]              rdPtr;
	logic [cntWidth-1:0]              fifoCount;

	// Pointer step with wrap at the FIFO depth
	function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
		if (ptr == ptrWidth'(fifoDepth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign enRise   = dmaCfg.dmaEnable & ~enPrev;
	assign lastAdrs = curAdrs >= dmaCfg.adrsEnd;
	// Late responses after disable are dropped
	assign push     = (state == DMA_WAIT) & ufiRsp.rdy & dmaCfg.dmaEnable;
	assign pop      = dmaRe & (fifoCount != '0);

	// Request stays up for the whole wait
	always_comb
	begin
		ufiReq.req  = (state == DMA_WAIT);
		ufiReq.adrs = curAdrs;
	end

	// ---------------------------------------------------------------------
	// Address walker
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state   <= DMA_IDLE;
			enPrev  <= 1'b0;
			curAdrs <= '0;
			dmaDone <= 1'b0;
		end
		else
		begin
			enPrev  <= dmaCfg.dmaEnable;
			dmaDone <= 1'b0;
			case (state)
				DMA_IDLE:
				begin
					// Start only on a fresh enable
					if (enRise)
					begin
						curAdrs <= dmaCfg.adrsStart;
						state   <= DMA_REQ;
					end
				end
				DMA_REQ:
				begin
					// One request in flight, so a free entry is enough
					if (!dmaCfg.dmaEnable)
						state <= DMA_IDLE;
					else if (fifoCount < cntWidth'(fifoDepth))
						state <= DMA_WAIT;
				end
				DMA_WAIT:
				begin
					if (ufiRsp.rdy)
					begin
						if (!dmaCfg.dmaEnable)
							state <= DMA_IDLE;
						else if (lastAdrs)
						begin
							// End of pass
							dmaDone <= 1'b1;
							if (dmaCfg.cycleEnable)
							begin
								curAdrs <= dmaCfg.adrsStart;
								state   <= DMA_REQ;
							end
							else
								state <= DMA_DONE;
						end
						else
						begin
							curAdrs <= curAdrs + dmaCfg.adrsAdd;
							state   <= DMA_REQ;
						end
					end
				end
				DMA_DONE:
				begin
					// Park until the host drops enable
					if (!dmaCfg.dmaEnable)
						state <= DMA_IDLE;
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// Sample FIFO
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (push)
			fifoMem[wrPtr] <= ufiRsp.rd;
	end

	always_ff @(posedge clk)
	begin
		// Disable flushes everything
		if (rst || !dmaCfg.dmaEnable)
		begin
			wrPtr     <= '0;
			rdPtr     <= '0;
			fifoCount <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10:   fifoCount <= fifoCount + 1'b1;
				2'b01:   fifoCount <= fifoCount - 1'b1;
				default: ;
			endcase
		end
	end

	// Head of queue
	assign dmaRd  = fifoMem[rdPtr];
	assign dmaRvd = (fifoCount != '0);

endmodule

//--- hw/SynthesizerCsr.sv
// Synthesizer control and status registers

`timescale 1ns/10ps
`include "synth_defines.svh"

module SynthesizerCsr (
	input  logic                          clk,
	input  logic                          rst,
	input  SynthBusPkg::usiWrT            usiWr,
	input  logic [`SYNTH_USI_WIDTH-1:0]   usiRdAdrs,
	input  logic                          dmaDone,
	output logic [`SYNTH_USI_WIDTH-1:0]   usiRd,
	output SynthAudioPkg::dmaCfgT         dmaCfg,
	output logic                          i2sRst
);

	// Full words kept so readback matches what was written
	logic [`SYNTH_USI_WIDTH-1:0] ctrlReg;
	logic [`SYNTH_USI_WIDTH-1:0] startReg;
	logic [`SYNTH_USI_WIDTH-1:0] endReg;
	logic [`SYNTH_USI_WIDTH-1:0] addReg;
	logic                        doneSticky;
	logic                        doneClr;

	// ---------------------------------------------------------------------
	// Write decode
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ctrlReg  <= '0;
			startReg <= '0;
			endReg   <= '0;
			addReg   <= '0;
		end
		else if (usiWr.wrEn)
		begin
			// Unmapped and status addresses fall through
			case (usiWr.adrs)
				`SYNTH_REG_CTRL:  ctrlReg  <= usiWr.wd;
				`SYNTH_REG_START: startReg <= usiWr.wd;
				`SYNTH_REG_END:   endReg   <= usiWr.wd;
				`SYNTH_REG_ADD:   addReg   <= usiWr.wd;
				default: ;
			endcase
		end
	end

	// Write one to clear the done flag
	assign doneClr = usiWr.wrEn & (usiWr.adrs == `SYNTH_REG_STATUS) & usiWr.wd[0];

	// Sticky done, a new pulse beats a clear
	always_ff @(posedge clk)
	begin
		if (rst)
			doneSticky <= 1'b0;
		else
			doneSticky <= dmaDone | (doneSticky & ~doneClr);
	end

	// ---------------------------------------------------------------------
	// Registered readback
	// ---------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
			usiRd <= '0;
		else
		begin
			case (usiRdAdrs)
				`SYNTH_REG_CTRL:   usiRd <= ctrlReg;
				`SYNTH_REG_START:  usiRd <= startReg;
				`SYNTH_REG_END:    usiRd <= endReg;
				`SYNTH_REG_ADD:    usiRd <= addReg;
				`SYNTH_REG_STATUS: usiRd <= {{(`SYNTH_USI_WIDTH-1){1'b0}}, doneSticky};
				default:           usiRd <= '0;
			endcase
		end
	end

	// Fields out to the DMA and I2S blocks
	always_comb
	begin
		dmaCfg.dmaEnable   = ctrlReg[`SYNTH_CTRL_DMA_EN];
		dmaCfg.cycleEnable = ctrlReg[`SYNTH_CTRL_CYCLE_EN];
		dmaCfg.adrsStart   = startReg[`SYNTH_DMA_ADRS_WIDTH-1:0];
		dmaCfg.adrsEnd     = endReg[`SYNTH_DMA_ADRS_WIDTH-1:0];
		dmaCfg.adrsAdd     = addReg[`SYNTH_DMA_ADRS_WIDTH-1:0];
	end

	assign i2sRst = ctrlReg[`SYNTH_CTRL_I2S_RST];

endmodule

//--- hw/SynthAudioPkg.sv
// Synthesizer audio and control types

`include "synth_defines.svh"

package SynthAudioPkg;

	// DMA walker states
	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_REQ,
		DMA_WAIT,
		DMA_DONE
	} dmaStateT;

	// MIDI receiver states
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uartStateT;

	// I2S word, sample sits in bits 30..15
	typedef struct packed {
		logic                           pad;
		logic [`SYNTH_UFI_DQ_WIDTH-1:0] sample;
		logic [14:0]                    zero;
	} audioWordT;

	// DMA setup from the CSR block
	typedef struct packed {
		logic                             dmaEnable;
		logic                             cycleEnable;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsStart;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsEnd;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrsAdd;
	} dmaCfgT;

endpackage

//--- hw/SynthBusPkg.sv
// Synthesizer bus types

`include "synth_defines.svh"

package SynthBusPkg;

	// ---------------------------------------------------------------------
	// Register bus
	// ---------------------------------------------------------------------
	// One write per cycle with wrEn high
	typedef struct packed {
		logic                        wrEn;
		logic [`SYNTH_USI_WIDTH-1:0] adrs;
		logic [`SYNTH_USI_WIDTH-1:0] wd;
	} usiWrT;

	// ---------------------------------------------------------------------
	// Sample memory port
	// ---------------------------------------------------------------------
	// Request held until rdy comes back
	typedef struct packed {
		logic                             req;
		logic [`SYNTH_DMA_ADRS_WIDTH-1:0] adrs;
	} ufiReqT;

	// Single-cycle rdy with read data
	typedef struct packed {
		logic                           rdy;
		logic [`SYNTH_UFI_DQ_WIDTH-1:0] rd;
	} ufiRspT;

endpackage

//--- hw/synth_defines.svh
// Synthesizer shared constants

`ifndef SYNTH_DEFINES_SVH
`define SYNTH_DEFINES_SVH

// ---------------------------------------------------------------------
// Bus widths
// ---------------------------------------------------------------------
`define SYNTH_USI_WIDTH       32
`define SYNTH_DMA_ADRS_WIDTH  18
`define SYNTH_UFI_DQ_WIDTH    16

// Register map, byte addresses
`define SYNTH_REG_CTRL        32'd0
`define SYNTH_REG_START       32'd4
`define SYNTH_REG_END         32'd8
`define SYNTH_REG_ADD         32'd12
`define SYNTH_REG_STATUS      32'd16

// Control register bits
`define SYNTH_CTRL_DMA_EN     0
`define SYNTH_CTRL_CYCLE_EN   1
`define SYNTH_CTRL_I2S_RST    2

// Sample FIFO and clock dividers
`define SYNTH_DMA_FIFO_DEPTH  4
`define SYNTH_I2S_BCLK_DIV    2
// Scaled down for simulation, 3200 on the board
`define SYNTH_MIDI_BAUD_DIV   32

`endif
